// ==== ppu_pkg.sv ====
// ==========================================================
// PPU package
// Widths, pixel and configuration structs, video mode enums
// ==========================================================
`default_nettype none

package ppu_pkg;

  // ==========================================================
  // Widths
  // ==========================================================
  localparam int COLOR_W_I  = 7;
  localparam int COLOR_W_O  = 8;
  localparam int LINE_CNT_W = 10;

  // One demultiplexed N64 pixel, sync flags active high
  typedef struct packed {
    logic                 vsync;
    logic                 hsync;
    logic [COLOR_W_I-1:0] r;
    logic [COLOR_W_I-1:0] g;
    logic [COLOR_W_I-1:0] b;
  } n64_pixel_t;

  // One output pixel
  typedef struct packed {
    logic                 vsync;
    logic                 hsync;
    logic                 de;
    logic [COLOR_W_O-1:0] r;
    logic [COLOR_W_O-1:0] g;
    logic [COLOR_W_O-1:0] b;
  } vid_out_t;

  // ==========================================================
  // Output targets and video modes
  // ==========================================================
  // T_240P also stands for the 288p target in PAL
  typedef enum logic [2:0] {
    T_480P, T_720P, T_960P, T_1080P, T_1200P, T_1440P, T_1440WP, T_240P
  } target_res_e;

  typedef enum logic [4:0] {
    USE_VGAp60, USE_480p60, USE_576p50,
    USE_720p60, USE_720p50, USE_960p60, USE_960p50,
    USE_1080p60, USE_1080p50, USE_1200p60, USE_1200p50,
    USE_1440p60, USE_1440p50, USE_1440Wp60, USE_1440Wp50,
    USE_240p60, USE_288p50
  } vmode_e;

  // Host configuration word
  typedef struct packed {
    target_res_e target;
    logic        use_vga_480p;
    logic        force60;
    logic        force50;
    logic        lowlatency;
    logic        n16bit_mode;  // 0 selects 16-bit colour
    logic        sl_en;
    logic [3:0]  sl_str;
  } ppu_cfg_t;

  // Status word reported back to the host
  typedef struct packed {
    logic   vdata_detected;
    logic   palmode;
    logic   n64_480i;
    vmode_e vmode;
    logic   color_16bit;
    logic   lowlatency;
    logic   sl_en;
  } ppu_state_t;

endpackage

`default_nettype wire

// ==== n64_vdemux.sv ====
// ==========================================================
// N64 video demultiplexer
// Rebuilds whole pixels from the sync, R, G and B phases
// ==========================================================
`timescale 1ns/1ns
`default_nettype none

module n64_vdemux import ppu_pkg::*; (
  input  logic                 N64_CLK_i,
  input  logic                 reset_i,
  input  logic                 nVDSYNC_i,
  input  logic [COLOR_W_I-1:0] VD_i,
  input  logic                 n16bit_mode_i,
  output logic                 pix_valid_o,
  output n64_pixel_t           pix_o
);

  // Phase 0 idles until the next sync phase
  logic [1:0]           phase_q;
  logic                 vsync_hold_q;
  logic                 hsync_hold_q;
  logic [COLOR_W_I-1:0] r_hold_q;
  logic [COLOR_W_I-1:0] g_hold_q;
  logic [COLOR_W_I-1:0] color_mask;

  // Two LSBs dropped in 16-bit mode
  assign color_mask = n16bit_mode_i ? {COLOR_W_I{1'b1}} : {{(COLOR_W_I-2){1'b1}}, 2'b00};

  always_ff @(posedge N64_CLK_i) begin
    if (reset_i) begin
      phase_q     <= 2'd0;
      pix_valid_o <= 1'b0;
    end else begin
      pix_valid_o <= 1'b0;
      if (!nVDSYNC_i) begin
        phase_q <= 2'd1;
      end else begin
        case (phase_q)
          2'd1:    phase_q <= 2'd2;
          2'd2:    phase_q <= 2'd3;
          2'd3: begin
            phase_q     <= 2'd0;
            pix_valid_o <= 1'b1;
          end
          default: phase_q <= 2'd0;
        endcase
      end
    end
  end

  // Holding registers for the sync nibble and colour phases
  always_ff @(posedge N64_CLK_i) begin
    if (!nVDSYNC_i) begin
      // Nibble is {vsync_n, clamp_n, hsync_n, csync_n}
      vsync_hold_q <= ~VD_i[3];
      hsync_hold_q <= ~VD_i[1];
    end else if (phase_q == 2'd1) begin
      r_hold_q <= VD_i;
    end else if (phase_q == 2'd2) begin
      g_hold_q <= VD_i;
    end else if (phase_q == 2'd3) begin
      pix_o.vsync <= vsync_hold_q;
      pix_o.hsync <= hsync_hold_q;
      pix_o.r     <= r_hold_q & color_mask;
      pix_o.g     <= g_hold_q & color_mask;
      pix_o.b     <= VD_i & color_mask;
    end
  end

endmodule

`default_nettype wire

// ==== n64_vinfo.sv ====
// ==========================================================
// N64 video info detection
// Lines per field give PAL/NTSC and progressive/interlaced
// ==========================================================
`timescale 1ns/1ns
`default_nettype none

module n64_vinfo import ppu_pkg::*; #(
  parameter int PAL_LINES_MIN = 288
) (
  input  logic       N64_CLK_i,
  input  logic       reset_i,
  input  logic       pix_valid_i,
  input  n64_pixel_t pix_i,
  output logic       vdata_detected_o,
  output logic       palmode_o,
  output logic       n64_480i_o
);

  logic                  hsync_q;
  logic                  vsync_q;
  logic                  hs_rise;
  logic                  vs_rise;
  logic [LINE_CNT_W-1:0] line_cnt_q;
  logic [LINE_CNT_W-1:0] prev_cnt_q;
  // Saturates at 2 fields
  logic [1:0]            field_cnt_q;

  // Edges are taken between consecutive valid pixels only
  assign hs_rise = pix_valid_i & pix_i.hsync & ~hsync_q;
  assign vs_rise = pix_valid_i & pix_i.vsync & ~vsync_q;

  assign vdata_detected_o = field_cnt_q[1];

  always_ff @(posedge N64_CLK_i) begin
    if (reset_i) begin
      hsync_q     <= 1'b0;
      vsync_q     <= 1'b0;
      line_cnt_q  <= '0;
      prev_cnt_q  <= '0;
      field_cnt_q <= 2'd0;
      palmode_o   <= 1'b0;
      n64_480i_o  <= 1'b0;
    end else begin
      if (pix_valid_i) begin
        hsync_q <= pix_i.hsync;
        vsync_q <= pix_i.vsync;
      end
      if (vs_rise) begin
        // A line start on the field-start pixel opens line 1
        line_cnt_q <= hs_rise ? LINE_CNT_W'(1) : '0;
        prev_cnt_q <= line_cnt_q;
        if (!field_cnt_q[1])
          field_cnt_q <= field_cnt_q + 2'd1;
        // First edge has no complete field behind it
        if (field_cnt_q != 2'd0) begin
          palmode_o  <= (line_cnt_q > LINE_CNT_W'(PAL_LINES_MIN));
          n64_480i_o <= (line_cnt_q != prev_cnt_q);
        end
      end else if (hs_rise) begin
        line_cnt_q <= line_cnt_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== vmode_select.sv ====
// ==========================================================
// Output video mode selection
// Registers the config and builds the PPU state word
// ==========================================================
`timescale 1ns/1ns
`default_nettype none

module vmode_select import ppu_pkg::*; (
  input  logic       N64_CLK_i,
  input  logic       reset_i,
  input  ppu_cfg_t   cfg_i,
  input  logic       vdata_detected_i,
  input  logic       palmode_i,
  input  logic       n64_480i_i,
  output logic       n16bit_mode_o,
  output logic       sl_en_o,
  output logic [3:0] sl_str_o,
  output ppu_state_t state_o
);

  ppu_cfg_t cfg_q;
  vmode_e   vmode_ntsc;
  vmode_e   vmode_pal;
  vmode_e   vmode_next;
  logic     use_force60;
  logic     use_force50;

  always_comb begin
    case (cfg_i.target)
      T_1440WP: vmode_ntsc = USE_1440Wp60;
      T_1440P:  vmode_ntsc = USE_1440p60;
      T_1200P:  vmode_ntsc = USE_1200p60;
      T_1080P:  vmode_ntsc = USE_1080p60;
      T_960P:   vmode_ntsc = USE_960p60;
      T_720P:   vmode_ntsc = USE_720p60;
      T_240P:   vmode_ntsc = USE_240p60;
      default:  vmode_ntsc = cfg_i.use_vga_480p ? USE_VGAp60 : USE_480p60;
    endcase
    case (cfg_i.target)
      T_1440WP: vmode_pal = USE_1440Wp50;
      T_1440P:  vmode_pal = USE_1440p50;
      T_1200P:  vmode_pal = USE_1200p50;
      T_1080P:  vmode_pal = USE_1080p50;
      T_960P:   vmode_pal = USE_960p50;
      T_720P:   vmode_pal = USE_720p50;
      T_480P:   vmode_pal = USE_576p50;
      default:  vmode_pal = USE_288p50;
    endcase
  end

  // No forcing in low latency mode, nor 60 Hz in 288p and 50 Hz in 240p
  assign use_force60 = cfg_i.force60 & ~cfg_i.lowlatency &
                       ~(palmode_i & (cfg_i.target == T_240P));
  assign use_force50 = cfg_i.force50 & ~cfg_i.lowlatency & (cfg_i.target != T_240P);

  assign vmode_next = use_force60 ? vmode_ntsc :
                      use_force50 ? vmode_pal  :
                      palmode_i   ? vmode_pal  : vmode_ntsc;

  always_ff @(posedge N64_CLK_i) begin
    if (reset_i) begin
      cfg_q             <= '0;
      cfg_q.n16bit_mode <= 1'b1;
      state_o           <= '0;
    end else begin
      cfg_q                  <= cfg_i;
      state_o.vdata_detected <= vdata_detected_i;
      state_o.palmode        <= palmode_i;
      state_o.n64_480i       <= n64_480i_i;
      state_o.vmode          <= vmode_next;
      state_o.color_16bit    <= ~cfg_i.n16bit_mode;
      state_o.lowlatency     <= cfg_i.lowlatency;
      state_o.sl_en          <= cfg_i.sl_en;
    end
  end

  assign n16bit_mode_o = cfg_q.n16bit_mode;
  assign sl_en_o       = cfg_q.sl_en;
  assign sl_str_o      = cfg_q.sl_str;

endmodule

`default_nettype wire

// ==== scanline_emu.sv ====
// ==========================================================
// Scanline emulation
// Expands colour to 8 bits and darkens every odd line
// ==========================================================
`timescale 1ns/1ns
`default_nettype none

module scanline_emu import ppu_pkg::*; (
  input  logic       N64_CLK_i,
  input  logic       reset_i,
  input  logic       pix_valid_i,
  input  n64_pixel_t pix_i,
  input  logic       sl_en_i,
  input  logic [3:0] sl_str_i,
  output logic       vid_valid_o,
  output vid_out_t   vid_o
);

  logic       hsync_q;
  logic       odd_line_q;
  logic       odd_line;
  logic       darken;
  logic [7:0] strength;

  // Copy the MSB into the new LSB
  function automatic logic [COLOR_W_O-1:0] expand(input logic [COLOR_W_I-1:0] c);
    return {c, c[COLOR_W_I-1]};
  endfunction

  function automatic logic [COLOR_W_O-1:0] scale(input logic [COLOR_W_O-1:0] c,
                                                 input logic [7:0] s,
                                                 input logic en);
    logic [COLOR_W_O+7:0] prod;
    prod = c * s;
    return en ? prod[COLOR_W_O+7:8] : c;
  endfunction

  // (str + 1) * 16 - 1
  assign strength = {sl_str_i, 4'hF};

  // Parity of the line the current pixel belongs to
  assign odd_line = pix_i.vsync ? 1'b0 :
                    (pix_i.hsync & ~hsync_q) ? ~odd_line_q : odd_line_q;
  assign darken   = sl_en_i & odd_line;

  always_ff @(posedge N64_CLK_i) begin
    if (reset_i) begin
      hsync_q     <= 1'b0;
      odd_line_q  <= 1'b0;
      vid_valid_o <= 1'b0;
      vid_o.vsync <= 1'b0;
      vid_o.hsync <= 1'b0;
      vid_o.de    <= 1'b0;
    end else begin
      vid_valid_o <= pix_valid_i;
      if (pix_valid_i) begin
        hsync_q     <= pix_i.hsync;
        odd_line_q  <= odd_line;
        vid_o.vsync <= pix_i.vsync;
        vid_o.hsync <= pix_i.hsync;
        vid_o.de    <= ~pix_i.vsync & ~pix_i.hsync;
      end
    end
  end

  // Colour payload
  always_ff @(posedge N64_CLK_i) begin
    if (pix_valid_i) begin
      vid_o.r <= scale(expand(pix_i.r), strength, darken);
      vid_o.g <= scale(expand(pix_i.g), strength, darken);
      vid_o.b <= scale(expand(pix_i.b), strength, darken);
    end
  end

endmodule

`default_nettype wire

// ==== ppu_top.sv ====
// ==========================================================
// N64 post-processor front end
// Demux, video info, mode selection and scanline stage
// ==========================================================
`timescale 1ns/1ns
`default_nettype none

module ppu_top import ppu_pkg::*; #(
  parameter int PAL_LINES_MIN = 288
) (
  input  logic                 N64_CLK_i,
  input  logic                 reset_i,
  input  logic                 nVDSYNC_i,
  input  logic [COLOR_W_I-1:0] VD_i,
  input  ppu_cfg_t             ConfigSet_i,
  output ppu_state_t           PPUState_o,
  output logic                 vid_valid_o,
  output vid_out_t             vid_o
);

  logic       pix_valid;
  n64_pixel_t pix;
  logic       vdata_detected;
  logic       palmode;
  logic       n64_480i;
  logic       n16bit_mode;
  logic       sl_en;
  logic [3:0] sl_str;

  // ==========================================================
  // Input side
  // ==========================================================
  n64_vdemux vdemux_u (
    .N64_CLK_i     (N64_CLK_i),
    .reset_i       (reset_i),
    .nVDSYNC_i     (nVDSYNC_i),
    .VD_i          (VD_i),
    .n16bit_mode_i (n16bit_mode),
    .pix_valid_o   (pix_valid),
    .pix_o         (pix)
  );

  n64_vinfo #(
    .PAL_LINES_MIN (PAL_LINES_MIN)
  ) vinfo_u (
    .N64_CLK_i        (N64_CLK_i),
    .reset_i          (reset_i),
    .pix_valid_i      (pix_valid),
    .pix_i            (pix),
    .vdata_detected_o (vdata_detected),
    .palmode_o        (palmode),
    .n64_480i_o       (n64_480i)
  );

  // ==========================================================
  // Config and output side
  // ==========================================================
  vmode_select vmode_select_u (
    .N64_CLK_i        (N64_CLK_i),
    .reset_i          (reset_i),
    .cfg_i            (ConfigSet_i),
    .vdata_detected_i (vdata_detected),
    .palmode_i        (palmode),
    .n64_480i_i       (n64_480i),
    .n16bit_mode_o    (n16bit_mode),
    .sl_en_o          (sl_en),
    .sl_str_o         (sl_str),
    .state_o          (PPUState_o)
  );

  scanline_emu scanline_emu_u (
    .N64_CLK_i   (N64_CLK_i),
    .reset_i     (reset_i),
    .pix_valid_i (pix_valid),
    .pix_i       (pix),
    .sl_en_i     (sl_en),
    .sl_str_i    (sl_str),
    .vid_valid_o (vid_valid_o),
    .vid_o       (vid_o)
  );

endmodule

`default_nettype wire

// ==== tb_ppu_top.sv ====
// ==========================================================
// Testbench for the N64 post-processor front end
// Random pixels through the demux, vinfo and mode checks
// ==========================================================
`timescale 1ns/1ns
`default_nettype none

module tb_ppu_top import ppu_pkg::*; ();

  localparam int PAL_LINES_MIN = 288;
  localparam int PIX_PER_LINE  = 4;
  // Sync, R, G and B phase per pixel
  localparam int CYC_PER_LINE  = PIX_PER_LINE * 4;
  localparam int SENT_LINES    = 8 + 8 + 4 * 6 + 3 * 263 + 262 + 313 + 2;
  localparam int SWEEP_CYCLES  = 2 * 128 * 3;
  localparam int TIMEOUT_CYCLES = 2 * (SENT_LINES * CYC_PER_LINE + SWEEP_CYCLES);

  typedef struct packed {
    n64_pixel_t pix;
    logic       odd;
    ppu_cfg_t   cfg;
  } sent_t;

  logic                 N64_CLK_i;
  logic                 reset_i;
  logic                 nVDSYNC_i;
  logic [COLOR_W_I-1:0] VD_i;
  ppu_cfg_t             ConfigSet_i;
  ppu_state_t           PPUState_o;
  logic                 vid_valid_o;
  vid_out_t             vid_o;

  sent_t    sent_q[$];
  ppu_cfg_t cur_cfg;
  int       seed;
  int       cycle_cnt = 0;
  int       check_cnt = 0;
  int       err_cnt = 0;
  int       mark_checks = 0;
  int       mark_errs = 0;
  // Video info model
  int       m_fields;
  int       m_open_len;
  int       m_prev_len;
  logic     m_pal;
  logic     m_480i;
  logic     m_vdata;

  ppu_top #(
    .PAL_LINES_MIN (PAL_LINES_MIN)
  ) UUT (
    .N64_CLK_i   (N64_CLK_i),
    .reset_i     (reset_i),
    .nVDSYNC_i   (nVDSYNC_i),
    .VD_i        (VD_i),
    .ConfigSet_i (ConfigSet_i),
    .PPUState_o  (PPUState_o),
    .vid_valid_o (vid_valid_o),
    .vid_o       (vid_o)
  );

  initial begin
    N64_CLK_i = 1'b0;
    forever #20 N64_CLK_i = ~N64_CLK_i;
  end

  // ==========================================================
  // Reference functions
  // ==========================================================
  function automatic logic [7:0] expected_color(input logic [6:0] c, input logic dark,
                                                input logic [3:0] str, input logic mode16);
    logic [6:0] m;
    int         wide;
    int         s;
    m = mode16 ? {c[6:2], 2'b00} : c;
    // Colour followed by its own MSB
    wide = m * 2 + m[6];
    s = (str + 1) * 16 - 1;
    if (dark)
      wide = wide * s / 256;
    return 8'(wide);
  endfunction

  function automatic vid_out_t expected_pixel(input n64_pixel_t pix, input logic odd,
                                              input ppu_cfg_t cfg, input logic mode16);
    vid_out_t v;
    v.vsync = pix.vsync;
    v.hsync = pix.hsync;
    v.de    = !pix.vsync && !pix.hsync;
    v.r     = expected_color(pix.r, odd && cfg.sl_en, cfg.sl_str, mode16);
    v.g     = expected_color(pix.g, odd && cfg.sl_en, cfg.sl_str, mode16);
    v.b     = expected_color(pix.b, odd && cfg.sl_en, cfg.sl_str, mode16);
    return v;
  endfunction

  function automatic vmode_e expected_vmode(input ppu_cfg_t cfg, input logic pal);
    logic   f60;
    logic   f50;
    logic   use_pal;
    vmode_e mode;
    f60 = cfg.force60 && !cfg.lowlatency && (!pal || cfg.target != T_240P);
    f50 = cfg.force50 && !cfg.lowlatency && cfg.target != T_240P;
    use_pal = f60 ? 1'b0 : (f50 ? 1'b1 : pal);
    case (cfg.target)
      T_1440WP: mode = use_pal ? USE_1440Wp50 : USE_1440Wp60;
      T_1440P:  mode = use_pal ? USE_1440p50 : USE_1440p60;
      T_1200P:  mode = use_pal ? USE_1200p50 : USE_1200p60;
      T_1080P:  mode = use_pal ? USE_1080p50 : USE_1080p60;
      T_960P:   mode = use_pal ? USE_960p50 : USE_960p60;
      T_720P:   mode = use_pal ? USE_720p50 : USE_720p60;
      T_240P:   mode = use_pal ? USE_288p50 : USE_240p60;
      default:  mode = use_pal ? USE_576p50 : (cfg.use_vga_480p ? USE_VGAp60 : USE_480p60);
    endcase
    return mode;
  endfunction

  // ==========================================================
  // Checks
  // ==========================================================
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("[FAIL] %0t ns %s: got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic check_state();
    ppu_state_t exp;
    exp.vdata_detected = m_vdata;
    exp.palmode        = m_pal;
    exp.n64_480i       = m_480i;
    exp.vmode          = expected_vmode(cur_cfg, m_pal);
    exp.color_16bit    = ~cur_cfg.n16bit_mode;
    exp.lowlatency     = cur_cfg.lowlatency;
    exp.sl_en          = cur_cfg.sl_en;
    check_value("PPUState_o", PPUState_o, exp);
  endtask

  // Pops the oldest sent pixel on every output strobe
  always @(posedge N64_CLK_i) begin : compare_output
    sent_t s;
    if (!reset_i && vid_valid_o === 1'b1) begin
      check_cnt++;
      assert (sent_q.size() > 0) else begin
        err_cnt++;
        $display("At %0t ns the DUT sent a pixel that was never driven", $time);
      end
      if (sent_q.size() > 0) begin
        s = sent_q.pop_front();
        check_value("vid_o", vid_o, expected_pixel(s.pix, s.odd, s.cfg, ~s.cfg.n16bit_mode));
      end
    end
  end

  always @(posedge N64_CLK_i) begin : watchdog
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles without finishing", cycle_cnt);
      $display("Test FAILED");
      $finish;
    end
  end

  // ==========================================================
  // Stimulus
  // ==========================================================
  task automatic reset_dut();
    @(posedge N64_CLK_i);
    reset_i <= 1'b1;
    repeat (4) @(posedge N64_CLK_i);
    reset_i <= 1'b0;
    m_fields   = 0;
    m_open_len = 0;
    m_prev_len = 0;
    m_pal      = 1'b0;
    m_480i     = 1'b0;
    m_vdata    = 1'b0;
    @(posedge N64_CLK_i);
    check_value("vid_valid_o", vid_valid_o, 0);
    check_value("vid_o sync/de", {vid_o.vsync, vid_o.hsync, vid_o.de}, 0);
    check_value("PPUState_o vinfo",
                {PPUState_o.vdata_detected, PPUState_o.palmode, PPUState_o.n64_480i}, 0);
    @(posedge N64_CLK_i);
  endtask

  task automatic apply_cfg(input ppu_cfg_t c);
    @(posedge N64_CLK_i);
    ConfigSet_i <= c;
    cur_cfg = c;
    @(posedge N64_CLK_i);
    @(posedge N64_CLK_i);
  endtask

  task automatic send_pixel(input logic vs, input logic hs, input logic odd);
    n64_pixel_t  p;
    sent_t       s;
    logic [31:0] rnd;
    rnd = $random(seed);
    p.vsync = vs;
    p.hsync = hs;
    p.r = rnd[6:0];
    p.g = rnd[13:7];
    p.b = rnd[20:14];
    s.pix = p;
    s.odd = odd;
    s.cfg = cur_cfg;
    sent_q.push_back(s);
    // Nibble is vsync_n, clamp_n, hsync_n, csync_n
    @(posedge N64_CLK_i);
    nVDSYNC_i <= 1'b0;
    VD_i <= {3'b000, ~vs, 1'b1, ~hs, ~(vs | hs)};
    @(posedge N64_CLK_i);
    nVDSYNC_i <= 1'b1;
    VD_i <= p.r;
    @(posedge N64_CLK_i);
    VD_i <= p.g;
    @(posedge N64_CLK_i);
    VD_i <= p.b;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (sent_q.size() != 0 && waited < 16) begin
      @(posedge N64_CLK_i);
      waited++;
    end
    assert (sent_q.size() == 0) else begin
      err_cnt++;
      $display("%0d pixels never came out of the DUT", sent_q.size());
      sent_q.delete();
    end
  endtask

  // The vsync pixel closes the previous field
  task automatic send_field(input int n_lines);
    if (m_fields != 0) begin
      m_pal  = m_open_len > PAL_LINES_MIN;
      m_480i = m_open_len != m_prev_len;
    end
    m_prev_len = m_open_len;
    if (m_fields < 2)
      m_fields++;
    m_vdata = m_fields >= 2;
    m_open_len = n_lines;
    for (int ln = 0; ln < n_lines; ln++) begin
      for (int px = 0; px < PIX_PER_LINE; px++)
        send_pixel(ln == 0 && px == 0, px == 0, ln[0]);
    end
    drain();
    @(posedge N64_CLK_i);
    check_state();
  endtask

  task automatic end_test(input string name);
    $display("%s: %0d checks, %0d errors", name, check_cnt - mark_checks, err_cnt - mark_errs);
    mark_checks = check_cnt;
    mark_errs = err_cnt;
  endtask

  initial begin : stimulus
    ppu_cfg_t c;
    int       vinfo_fields [6] = '{263, 263, 262, 263, 313, 2};
    seed = 32'h7ac49186;
    reset_i = 1'b1;
    nVDSYNC_i = 1'b1;
    VD_i = '0;
    c = '0;
    c.target = T_480P;
    c.n16bit_mode = 1'b1;
    ConfigSet_i = c;
    cur_cfg = c;
    reset_dut();

    apply_cfg(c);
    send_field(8);
    end_test("[1] plain pixels");

    c.n16bit_mode = 1'b0;
    apply_cfg(c);
    send_field(8);
    end_test("[2] 16-bit colour");

    c.n16bit_mode = 1'b1;
    c.sl_en = 1'b1;
    for (int s = 0; s < 16; s += 5) begin
      c.sl_str = 4'(s);
      apply_cfg(c);
      send_field(6);
    end
    end_test("[3] scanlines");

    c.sl_en = 1'b0;
    apply_cfg(c);
    reset_dut();
    foreach (vinfo_fields[i])
      send_field(vinfo_fields[i]);
    end_test("[4] video info");

    // First pass with palmode set by the 313 line field, then after reset
    for (int pass = 0; pass < 2; pass++) begin
      if (pass == 1)
        reset_dut();
      for (int t = 0; t < 8; t++) begin
        for (int k = 0; k < 16; k++) begin
          c.target = target_res_e'(t);
          c.force60 = k[0];
          c.force50 = k[1];
          c.lowlatency = k[2];
          c.use_vga_480p = k[3];
          apply_cfg(c);
          check_state();
        end
      end
    end
    end_test("[5] video mode");

    $display("Total: %0d checks, %0d errors, %0d cycles", check_cnt, err_cnt, cycle_cnt);
    if (err_cnt == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
ppu_pkg.sv
n64_vdemux.sv
n64_vinfo.sv
vmode_select.sv
scanline_emu.sv
ppu_top.sv
tb_ppu_top.sv

// ==== Bender.yml ====
package:
  name: n64_ppu_frontend

sources:
  - ppu_pkg.sv
  - n64_vdemux.sv
  - n64_vinfo.sv
  - vmode_select.sv
  - scanline_emu.sv
  - ppu_top.sv
  - target: test
    files:
      - tb_ppu_top.sv
